// ==== common/aud_settings.svh ====
`ifndef AUD_SETTINGS_SVH
`define AUD_SETTINGS_SVH

// codec sample width
`define AUD_SAMPLE_W 16

// external SRAM word address width
`define AUD_ADDR_W 20

// BCLK cycles per LRCK half period
`define AUD_SLOT_BCLKS 32

`endif

// ==== common/aud_pkg.sv ====
package aud_pkg;

	// recorder/player controller state, also shown on the display
	typedef enum logic [2:0] {
		ST_STOP       = 3'd0,
		ST_RECD       = 3'd1,
		ST_RECD_PAUSE = 3'd2,
		ST_PLAY       = 3'd3,
		ST_PLAY_PAUSE = 3'd4
	} ctrl_state_e;

	// playback speed modes
	typedef enum logic [1:0] {
		// one stored word per frame
		PM_NORMAL     = 2'd0,
		// skip ahead by the speed factor
		PM_FAST       = 2'd1,
		// repeat each word for speed factor frames
		PM_SLOW_CONST = 2'd2,
		// interpolate between neighbouring words
		PM_SLOW_LIN   = 2'd3
	} play_mode_e;

endpackage

// ==== aud_i2s/aud_recorder.sv ====
`timescale 1ns/1ns
`include "aud_settings.svh"

module aud_recorder #(
	parameter int P_MEM_WORDS = 1 << `AUD_ADDR_W
) (
	input  logic                     i_AUD_BCLK,
	input  logic                     i_rst_n,
	input  logic                     i_aud_adclrck,
	input  logic                     i_aud_adcdat,
	input  logic                     i_rec_en,
	input  logic                     i_rec_clear,
	output logic                     o_wr_stb,
	output logic [`AUD_ADDR_W-1:0]   o_wr_addr,
	output logic [`AUD_SAMPLE_W-1:0] o_wr_data,
	output logic [`AUD_ADDR_W:0]     o_rec_len,
	output logic                     o_rec_full
);

	localparam int CNT_W = $clog2(`AUD_SLOT_BCLKS + 1);
	localparam logic [CNT_W-1:0] SLOT_END = CNT_W'(`AUD_SLOT_BCLKS);
	localparam logic [CNT_W-1:0] LSB_CNT = CNT_W'(`AUD_SAMPLE_W);
	localparam logic [`AUD_ADDR_W:0] MEM_WORDS = (`AUD_ADDR_W+1)'(P_MEM_WORDS);
	localparam logic [`AUD_ADDR_W:0] MEM_LAST = (`AUD_ADDR_W+1)'(P_MEM_WORDS - 1);

	logic                     lrc_q;
	logic                     lrc_fall;
	logic [CNT_W-1:0]         bit_cnt;
	logic                     bit_slot;
	logic                     mem_full;
	logic [`AUD_SAMPLE_W-1:0] shift_q;
	logic [`AUD_ADDR_W:0]     word_cnt;

	// left slot starts when LRCK goes low
	assign lrc_fall = lrc_q & ~i_aud_adclrck;
	// bit_cnt 1 is the slot after the one-bit I2S delay
	assign bit_slot = (bit_cnt != '0) && (bit_cnt <= LSB_CNT);
	assign mem_full = word_cnt >= MEM_WORDS;

	assign o_wr_addr = word_cnt[`AUD_ADDR_W-1:0];
	assign o_wr_data = shift_q;
	assign o_rec_len = word_cnt;

	// sample bits, stable from the LSB until the next frame
	always_ff @(posedge i_AUD_BCLK) begin
		if (bit_slot) begin
			shift_q <= {shift_q[`AUD_SAMPLE_W-2:0], i_aud_adcdat};
		end
	end

	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			lrc_q      <= 1'b0;
			bit_cnt    <= '0;
			o_wr_stb   <= 1'b0;
			o_rec_full <= 1'b0;
			word_cnt   <= '0;
		end else begin
			lrc_q <= i_aud_adclrck;

			// counts the left half, then parks until the next fall
			if (lrc_fall) begin
				bit_cnt <= CNT_W'(1);
			end else if ((bit_cnt != '0) && (bit_cnt != SLOT_END)) begin
				bit_cnt <= bit_cnt + 1'b1;
			end

			// strobe follows the LSB sample by one cycle
			o_wr_stb <= (bit_cnt == LSB_CNT) && i_rec_en && !mem_full;

			o_rec_full <= o_wr_stb && (word_cnt == MEM_LAST);

			if (i_rec_clear) begin
				word_cnt <= '0;
			end else if (o_wr_stb) begin
				word_cnt <= word_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== aud_i2s/aud_player.sv ====
`timescale 1ns/1ns
`include "aud_settings.svh"

module aud_player (
	input  logic                     i_AUD_BCLK,
	input  logic                     i_rst_n,
	input  logic                     i_aud_daclrck,
	input  logic                     i_play_en,
	input  logic [`AUD_SAMPLE_W-1:0] i_dac_data,
	output logic                     o_aud_dacdat
);

	localparam int CNT_W = $clog2(`AUD_SLOT_BCLKS + 1);
	localparam logic [CNT_W-1:0] SLOT_END = CNT_W'(`AUD_SLOT_BCLKS);
	localparam logic [CNT_W-1:0] LSB_CNT = CNT_W'(`AUD_SAMPLE_W);

	logic                     lrc_q;
	logic                     lrc_fall;
	logic [CNT_W-1:0]         bit_cnt;
	logic                     bit_slot;
	logic [`AUD_SAMPLE_W-1:0] shift_q;

	assign lrc_fall = lrc_q & ~i_aud_daclrck;
	assign bit_slot = (bit_cnt != '0) && (bit_cnt <= LSB_CNT);

	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			lrc_q        <= 1'b0;
			bit_cnt      <= '0;
			shift_q      <= '0;
			o_aud_dacdat <= 1'b0;
		end else begin
			lrc_q <= i_aud_daclrck;

			if (lrc_fall) begin
				// a disabled frame is sent as silence
				bit_cnt      <= CNT_W'(1);
				shift_q      <= i_play_en ? i_dac_data : '0;
				o_aud_dacdat <= 1'b0;
			end else begin
				if ((bit_cnt != '0) && (bit_cnt != SLOT_END)) begin
					bit_cnt <= bit_cnt + 1'b1;
				end

				// MSB first, one bit per BCLK
				if (bit_slot) begin
					o_aud_dacdat <= shift_q[`AUD_SAMPLE_W-1];
					shift_q      <= {shift_q[`AUD_SAMPLE_W-2:0], 1'b0};
				end else begin
					o_aud_dacdat <= 1'b0;
				end
			end
		end
	end

endmodule

// ==== aud_dsp/aud_dsp.sv ====
`timescale 1ns/1ns
`include "aud_settings.svh"

module aud_dsp (
	input  logic                     i_AUD_BCLK,
	input  logic                     i_rst_n,
	input  logic                     i_aud_daclrck,
	input  logic                     i_play_start,
	input  logic                     i_play_en,
	input  aud_pkg::play_mode_e      i_mode,
	input  logic [2:0]               i_speed,
	input  logic [`AUD_ADDR_W:0]     i_rec_len,
	input  logic [`AUD_SAMPLE_W-1:0] i_sram_dq,
	output logic [`AUD_ADDR_W-1:0]   o_rd_addr,
	output logic [`AUD_SAMPLE_W-1:0] o_dac_data,
	output logic                     o_play_done
);

	typedef enum logic [1:0] {
		FS_IDLE = 2'd0,
		FS_RD0  = 2'd1,
		FS_RD1  = 2'd2,
		FS_CALC = 2'd3
	} fetch_state_e;

	fetch_state_e                    fs_q;
	logic                            lrc_q;
	logic                            lrc_fall;
	logic                            start_q;
	logic                            at_end;
	logic [`AUD_ADDR_W:0]            pos_q;
	logic [`AUD_ADDR_W:0]            pos_next1;
	logic [2:0]                      k_q;
	logic [3:0]                      n_fac;
	logic [`AUD_SAMPLE_W-1:0]        w0_q;
	logic [`AUD_SAMPLE_W-1:0]        w1_q;
	logic [`AUD_SAMPLE_W-1:0]        lin_val;
	logic signed [`AUD_SAMPLE_W:0]   diff;
	logic signed [`AUD_SAMPLE_W+3:0] prod;
	logic signed [`AUD_SAMPLE_W+3:0] quot;

	assign lrc_fall  = lrc_q & ~i_aud_daclrck;
	// speed factor N runs 1 to 8
	assign n_fac     = {1'b0, i_speed} + 4'd1;
	assign pos_next1 = pos_q + 1'b1;
	assign at_end    = pos_q >= i_rec_len;

	// w0 + (w1 - w0) * k / N, division truncates toward zero
	assign diff    = $signed({w1_q[`AUD_SAMPLE_W-1], w1_q}) - $signed({w0_q[`AUD_SAMPLE_W-1], w0_q});
	assign prod    = diff * $signed({1'b0, k_q});
	assign quot    = prod / $signed({1'b0, n_fac});
	assign lin_val = w0_q + quot[`AUD_SAMPLE_W-1:0];

	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			fs_q        <= FS_IDLE;
			lrc_q       <= 1'b0;
			start_q     <= 1'b0;
			pos_q       <= '0;
			k_q         <= '0;
			o_rd_addr   <= '0;
			o_play_done <= 1'b0;
		end else begin
			lrc_q   <= i_aud_daclrck;
			start_q <= i_play_start;

			// empty recording ends right after start, otherwise at the
			// first frame that finds the read position past the end
			o_play_done <= i_play_en && !o_play_done &&
				((start_q && (i_rec_len == '0)) || ((fs_q == FS_IDLE) && lrc_fall && at_end));

			if (i_play_start) begin
				fs_q  <= FS_IDLE;
				pos_q <= '0;
				k_q   <= '0;
			end else begin
				case (fs_q)
					FS_IDLE: begin
						if (lrc_fall && i_play_en && !at_end) begin
							o_rd_addr <= pos_q[`AUD_ADDR_W-1:0];
							fs_q      <= FS_RD0;
						end
					end
					FS_RD0: begin
						if (i_mode == aud_pkg::PM_SLOW_LIN) begin
							// last word pairs with itself
							o_rd_addr <= (pos_next1 < i_rec_len) ? pos_next1[`AUD_ADDR_W-1:0]
								: pos_q[`AUD_ADDR_W-1:0];
							fs_q      <= FS_RD1;
						end else begin
							fs_q <= FS_CALC;
						end
					end
					FS_RD1: begin
						fs_q <= FS_CALC;
					end
					default: begin
						fs_q <= FS_IDLE;
						case (i_mode)
							aud_pkg::PM_NORMAL: pos_q <= pos_next1;
							aud_pkg::PM_FAST:   pos_q <= pos_q + n_fac;
							default: begin
								// slow modes stay on one word for N frames
								if (k_q == i_speed) begin
									k_q   <= '0;
									pos_q <= pos_next1;
								end else begin
									k_q <= k_q + 1'b1;
								end
							end
						endcase
					end
				endcase
			end
		end
	end

	// SRAM data is valid in the cycle its address is driven
	always_ff @(posedge i_AUD_BCLK) begin
		if (fs_q == FS_RD0) begin
			w0_q <= i_sram_dq;
		end
		if (fs_q == FS_RD1) begin
			w1_q <= i_sram_dq;
		end
		if (i_play_start) begin
			o_dac_data <= '0;
		end else if (fs_q == FS_CALC) begin
			o_dac_data <= (i_mode == aud_pkg::PM_SLOW_LIN) ? lin_val : w0_q;
		end
	end

endmodule

// ==== src/aud_ctrl.sv ====
`timescale 1ns/1ns
`include "aud_settings.svh"

module aud_ctrl (
	input  logic                     i_AUD_BCLK,
	input  logic                     i_rst_n,
	input  logic                     i_key_rec,
	input  logic                     i_key_play,
	input  logic                     i_key_stop,
	input  aud_pkg::play_mode_e      i_mode_sel,
	input  logic [2:0]               i_speed,
	input  logic                     i_wr_stb,
	input  logic [`AUD_ADDR_W-1:0]   i_wr_addr,
	input  logic [`AUD_SAMPLE_W-1:0] i_wr_data,
	input  logic                     i_rec_full,
	input  logic [`AUD_ADDR_W-1:0]   i_rd_addr,
	input  logic                     i_play_done,
	output aud_pkg::ctrl_state_e     o_mode,
	output logic                     o_rec_en,
	output logic                     o_rec_clear,
	output logic                     o_play_start,
	output logic                     o_play_en,
	output aud_pkg::play_mode_e      o_play_mode,
	output logic [2:0]               o_play_speed,
	output logic [`AUD_ADDR_W-1:0]   o_sram_addr,
	output logic [`AUD_SAMPLE_W-1:0] o_sram_dq,
	output logic                     o_sram_we_n
);

	aud_pkg::ctrl_state_e state_q;
	aud_pkg::ctrl_state_e state_d;
	logic [2:0]           key_q;
	logic [2:0]           key_qq;
	logic                 press_rec;
	logic                 press_play;
	logic                 press_stop;
	logic                 start_rec;
	logic                 start_play;
	logic                 wr_sel;

	// press = key seen high for the first time
	assign press_rec  = key_q[0] & ~key_qq[0];
	assign press_play = key_q[1] & ~key_qq[1];
	assign press_stop = key_q[2] & ~key_qq[2];

	assign start_rec  = (state_q == aud_pkg::ST_STOP) && (state_d == aud_pkg::ST_RECD);
	assign start_play = (state_q == aud_pkg::ST_STOP) && (state_d == aud_pkg::ST_PLAY);

	always_comb begin
		state_d = state_q;
		case (state_q)
			aud_pkg::ST_STOP: begin
				if (press_rec) begin
					state_d = aud_pkg::ST_RECD;
				end else if (press_play) begin
					state_d = aud_pkg::ST_PLAY;
				end
			end
			aud_pkg::ST_RECD: begin
				if (press_stop || i_rec_full) begin
					state_d = aud_pkg::ST_STOP;
				end else if (press_rec) begin
					state_d = aud_pkg::ST_RECD_PAUSE;
				end
			end
			aud_pkg::ST_RECD_PAUSE: begin
				if (press_stop) begin
					state_d = aud_pkg::ST_STOP;
				end else if (press_rec) begin
					state_d = aud_pkg::ST_RECD;
				end
			end
			aud_pkg::ST_PLAY: begin
				if (press_stop || i_play_done) begin
					state_d = aud_pkg::ST_STOP;
				end else if (press_play) begin
					state_d = aud_pkg::ST_PLAY_PAUSE;
				end
			end
			aud_pkg::ST_PLAY_PAUSE: begin
				if (press_stop) begin
					state_d = aud_pkg::ST_STOP;
				end else if (press_play) begin
					state_d = aud_pkg::ST_PLAY;
				end
			end
			default: state_d = aud_pkg::ST_STOP;
		endcase
	end

	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			state_q      <= aud_pkg::ST_STOP;
			key_q        <= '0;
			key_qq       <= '0;
			o_rec_clear  <= 1'b0;
			o_play_start <= 1'b0;
			o_play_mode  <= aud_pkg::PM_NORMAL;
			o_play_speed <= '0;
		end else begin
			key_q        <= {i_key_stop, i_key_play, i_key_rec};
			key_qq       <= key_q;
			state_q      <= state_d;
			o_rec_clear  <= start_rec;
			o_play_start <= start_play;
			// mode and speed hold for the whole playback
			if (start_play) begin
				o_play_mode  <= i_mode_sel;
				o_play_speed <= i_speed;
			end
		end
	end

	assign o_mode    = state_q;
	assign o_rec_en  = state_q == aud_pkg::ST_RECD;
	assign o_play_en = state_q == aud_pkg::ST_PLAY;

	// SRAM port belongs to the recorder only for its write strobe
	assign wr_sel      = o_rec_en && i_wr_stb;
	assign o_sram_we_n = ~wr_sel;
	assign o_sram_addr = wr_sel ? i_wr_addr : i_rd_addr;
	assign o_sram_dq   = i_wr_data;

endmodule

// ==== src/aud_top.sv ====
`timescale 1ns/1ns
`include "aud_settings.svh"

module aud_top #(
	parameter int P_MEM_WORDS = 1 << `AUD_ADDR_W
) (
	input  logic                     i_AUD_BCLK,
	input  logic                     i_rst_n,
	input  logic                     i_key_rec,
	input  logic                     i_key_play,
	input  logic                     i_key_stop,
	input  aud_pkg::play_mode_e      i_mode_sel,
	input  logic [2:0]               i_speed,
	input  logic                     i_aud_adclrck,
	input  logic                     i_aud_adcdat,
	input  logic                     i_aud_daclrck,
	input  logic [`AUD_SAMPLE_W-1:0] i_sram_dq,
	output logic                     o_aud_dacdat,
	output logic [`AUD_ADDR_W-1:0]   o_sram_addr,
	output logic [`AUD_SAMPLE_W-1:0] o_sram_dq,
	output logic                     o_sram_we_n,
	output aud_pkg::ctrl_state_e     o_mode
);

	// controller to recorder
	logic                     rec_en;
	logic                     rec_clear;
	logic                     wr_stb;
	logic [`AUD_ADDR_W-1:0]   wr_addr;
	logic [`AUD_SAMPLE_W-1:0] wr_data;
	logic [`AUD_ADDR_W:0]     rec_len;
	logic                     rec_full;

	// controller to DSP and player
	logic                     play_start;
	logic                     play_en;
	aud_pkg::play_mode_e      play_mode;
	logic [2:0]               play_speed;
	logic [`AUD_ADDR_W-1:0]   rd_addr;
	logic [`AUD_SAMPLE_W-1:0] dac_data;
	logic                     play_done;

	aud_ctrl ctrl_i (
		.i_AUD_BCLK   (i_AUD_BCLK),
		.i_rst_n      (i_rst_n),
		.i_key_rec    (i_key_rec),
		.i_key_play   (i_key_play),
		.i_key_stop   (i_key_stop),
		.i_mode_sel   (i_mode_sel),
		.i_speed      (i_speed),
		.i_wr_stb     (wr_stb),
		.i_wr_addr    (wr_addr),
		.i_wr_data    (wr_data),
		.i_rec_full   (rec_full),
		.i_rd_addr    (rd_addr),
		.i_play_done  (play_done),
		.o_mode       (o_mode),
		.o_rec_en     (rec_en),
		.o_rec_clear  (rec_clear),
		.o_play_start (play_start),
		.o_play_en    (play_en),
		.o_play_mode  (play_mode),
		.o_play_speed (play_speed),
		.o_sram_addr  (o_sram_addr),
		.o_sram_dq    (o_sram_dq),
		.o_sram_we_n  (o_sram_we_n)
	);

	aud_recorder #(
		.P_MEM_WORDS (P_MEM_WORDS)
	) recorder_i (
		.i_AUD_BCLK    (i_AUD_BCLK),
		.i_rst_n       (i_rst_n),
		.i_aud_adclrck (i_aud_adclrck),
		.i_aud_adcdat  (i_aud_adcdat),
		.i_rec_en      (rec_en),
		.i_rec_clear   (rec_clear),
		.o_wr_stb      (wr_stb),
		.o_wr_addr     (wr_addr),
		.o_wr_data     (wr_data),
		.o_rec_len     (rec_len),
		.o_rec_full    (rec_full)
	);

	aud_dsp dsp_i (
		.i_AUD_BCLK    (i_AUD_BCLK),
		.i_rst_n       (i_rst_n),
		.i_aud_daclrck (i_aud_daclrck),
		.i_play_start  (play_start),
		.i_play_en     (play_en),
		.i_mode        (play_mode),
		.i_speed       (play_speed),
		.i_rec_len     (rec_len),
		.i_sram_dq     (i_sram_dq),
		.o_rd_addr     (rd_addr),
		.o_dac_data    (dac_data),
		.o_play_done   (play_done)
	);

	aud_player player_i (
		.i_AUD_BCLK    (i_AUD_BCLK),
		.i_rst_n       (i_rst_n),
		.i_aud_daclrck (i_aud_daclrck),
		.i_play_en     (play_en),
		.i_dac_data    (dac_data),
		.o_aud_dacdat  (o_aud_dacdat)
	);

endmodule

// ==== verification/aud_top_chk.sv ====
`timescale 1ns/1ns

module aud_top_chk (
	input logic                 i_AUD_BCLK,
	input logic                 i_rst_n,
	input logic                 i_sram_we_n,
	input logic                 i_rec_clear,
	input logic                 i_play_start,
	input logic                 i_play_done,
	input aud_pkg::ctrl_state_e i_mode
);

	int fail_cnt = 0;

	// SRAM is written only while recording
	we_in_recd: assert property (@(posedge i_AUD_BCLK) disable iff (i_rst_n)
		!i_sram_we_n |-> i_mode == aud_pkg::ST_RECD)
		else begin
			fail_cnt = fail_cnt + 1;
			$error("SRAM write while not recording");
		end

	rec_clear_pulse: assert property (@(posedge i_AUD_BCLK) disable iff (i_rst_n)
		i_rec_clear |=> !i_rec_clear)
		else begin
			fail_cnt = fail_cnt + 1;
			$error("rec_clear longer than one cycle");
		end

	play_start_pulse: assert property (@(posedge i_AUD_BCLK) disable iff (i_rst_n)
		i_play_start |=> !i_play_start)
		else begin
			fail_cnt = fail_cnt + 1;
			$error("play_start longer than one cycle");
		end

	play_done_pulse: assert property (@(posedge i_AUD_BCLK) disable iff (i_rst_n)
		i_play_done |=> !i_play_done)
		else begin
			fail_cnt = fail_cnt + 1;
			$error("play_done longer than one cycle");
		end

	mode_legal: assert property (@(posedge i_AUD_BCLK) disable iff (i_rst_n)
		i_mode inside {aud_pkg::ST_STOP, aud_pkg::ST_RECD, aud_pkg::ST_RECD_PAUSE,
			aud_pkg::ST_PLAY, aud_pkg::ST_PLAY_PAUSE})
		else begin
			fail_cnt = fail_cnt + 1;
			$error("controller state outside the defined set");
		end

endmodule

bind aud_top aud_top_chk chk_i (
	.i_AUD_BCLK   (i_AUD_BCLK),
	.i_rst_n      (i_rst_n),
	.i_sram_we_n  (o_sram_we_n),
	.i_rec_clear  (rec_clear),
	.i_play_start (play_start),
	.i_play_done  (play_done),
	.i_mode       (o_mode)
);

// ==== verification/tb_aud_top.sv ====
`timescale 1ns/1ns
`include "aud_settings.svh"

module tb_aud_top;

	localparam int MEM_WORDS = 64;
	localparam int FRAME_BCLKS = 2 * `AUD_SLOT_BCLKS;
	localparam int LOG_FRAMES = 1024;
	// record, record pause, four playbacks, memory full
	localparam int TEST_FRAMES = 24 + 17 + 14 + 8 + 27 + 44 + 69;
	localparam int TIMEOUT_CYCLES = TEST_FRAMES * FRAME_BCLKS + 4096;
	localparam int KEY_REC = 0;
	localparam int KEY_PLAY = 1;
	localparam int KEY_STOP = 2;

	logic                     aud_bclk;
	logic                     rst_n;
	logic                     key_rec;
	logic                     key_play;
	logic                     key_stop;
	aud_pkg::play_mode_e      mode_sel;
	logic [2:0]               speed;
	logic                     lrck;
	logic                     adcdat;
	logic [`AUD_SAMPLE_W-1:0] sram_rd;
	logic                     dacdat;
	logic [`AUD_ADDR_W-1:0]   sram_addr;
	logic [`AUD_SAMPLE_W-1:0] sram_wr;
	logic                     sram_we_n;
	aud_pkg::ctrl_state_e     mode;

	int                       seed = 36621;
	int                       phase;
	int                       frame;
	int                       now_frame;
	int                       stored_len;
	int                       errors;
	int                       checks;
	int                       tests;
	int                       test_err_start;
	int                       cycle_cnt;
	logic [`AUD_SAMPLE_W-1:0] cur_adc;
	logic [`AUD_SAMPLE_W-1:0] dac_shift;
	logic [`AUD_SAMPLE_W-1:0] adc_log [LOG_FRAMES];
	logic [`AUD_SAMPLE_W-1:0] dac_log [LOG_FRAMES];
	logic [`AUD_SAMPLE_W-1:0] mem [MEM_WORDS];

	aud_top #(
		.P_MEM_WORDS (MEM_WORDS)
	) dut_i (
		.i_AUD_BCLK    (aud_bclk),
		.i_rst_n       (rst_n),
		.i_key_rec     (key_rec),
		.i_key_play    (key_play),
		.i_key_stop    (key_stop),
		.i_mode_sel    (mode_sel),
		.i_speed       (speed),
		.i_aud_adclrck (lrck),
		.i_aud_adcdat  (adcdat),
		.i_aud_daclrck (lrck),
		.i_sram_dq     (sram_rd),
		.o_aud_dacdat  (dacdat),
		.o_sram_addr   (sram_addr),
		.o_sram_dq     (sram_wr),
		.o_sram_we_n   (sram_we_n),
		.o_mode        (mode)
	);

	always #5 aud_bclk = ~aud_bclk;

	// one LRCK for ADC and DAC, phase 0 starts the left slot
	always @(posedge aud_bclk) begin
		#1;
		phase = (phase + 1) % FRAME_BCLKS;
		if (phase == 0) begin
			frame = frame + 1;
			cur_adc = `AUD_SAMPLE_W'($random(seed));
			adc_log[frame] = cur_adc;
		end
		lrck = phase >= `AUD_SLOT_BCLKS;
		// MSB one BCLK after the fall
		adcdat = (phase >= 1 && phase <= `AUD_SAMPLE_W) ? cur_adc[`AUD_SAMPLE_W - phase] : 1'b0;
	end

	// asynchronous SRAM, read data follows the address
	assign sram_rd = mem[sram_addr[5:0]];

	always @(posedge aud_bclk) begin
		if (!sram_we_n) begin
			mem[sram_addr[5:0]] = sram_wr;
		end
	end

	// DAC bits appear one BCLK later than the ADC bits
	always @(posedge aud_bclk) begin
		if (phase >= 2 && phase <= `AUD_SAMPLE_W + 1) begin
			dac_shift = {dac_shift[`AUD_SAMPLE_W-2:0], dacdat};
		end
		if (phase == `AUD_SAMPLE_W + 1) begin
			dac_log[frame] = dac_shift;
		end
	end

	function automatic int out_count(input aud_pkg::play_mode_e pm, input int spd);
		int n;
		n = spd + 1;
		case (pm)
			aud_pkg::PM_NORMAL: return stored_len;
			aud_pkg::PM_FAST:   return (stored_len + n - 1) / n;
			default:            return stored_len * n;
		endcase
	endfunction

	// idx counts output frames after the leading zero frame
	function automatic logic [`AUD_SAMPLE_W-1:0] expected_sample(
		input aud_pkg::play_mode_e pm,
		input int                  spd,
		input int                  idx
	);
		int n;
		int p;
		int k;
		int a;
		int b;
		n = spd + 1;
		p = idx;
		k = 0;
		if (pm == aud_pkg::PM_FAST) begin
			p = idx * n;
		end else if (pm != aud_pkg::PM_NORMAL) begin
			p = idx / n;
			k = idx % n;
		end
		a = int'($signed(mem[p]));
		// last stored word pairs with itself
		b = (p + 1 < stored_len) ? int'($signed(mem[p + 1])) : a;
		if (pm == aud_pkg::PM_SLOW_LIN) begin
			return `AUD_SAMPLE_W'(a + (b - a) * k / n);
		end
		return mem[p];
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == test_err_start) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, errors - test_err_start);
		end
	endtask

	task automatic wait_phase(input int p);
		@(posedge aud_bclk);
		while (phase != p) begin
			@(posedge aud_bclk);
		end
		now_frame = frame;
		#1;
	endtask

	task automatic press_key(input int which);
		key_rec  = (which == KEY_REC);
		key_play = (which == KEY_PLAY);
		key_stop = (which == KEY_STOP);
		repeat (3) @(posedge aud_bclk);
		#1;
		key_rec  = 1'b0;
		key_play = 1'b0;
		key_stop = 1'b0;
	endtask

	task automatic wait_stop(input string name, output int stop_frame);
		int n;
		n = 0;
		@(posedge aud_bclk);
		while ((mode != aud_pkg::ST_STOP) && (n < 80 * FRAME_BCLKS)) begin
			@(posedge aud_bclk);
			n++;
		end
		if (mode != aud_pkg::ST_STOP) begin
			errors++;
			$display("%s: mode did not return to stop", name);
		end
		stop_frame = frame;
		#1;
	endtask

	// keys pressed in the right half, so whole left slots are taken or skipped
	task automatic run_record(input string name, input int n1, input int pause_frames, input int n2);
		int                       f;
		int                       h;
		int                       i;
		int                       stop_frame;
		int                       total;
		logic [`AUD_SAMPLE_W-1:0] next_old;
		total = n1 + n2;
		next_old = mem[total];
		test_err_start = errors;
		wait_phase(40);
		f = now_frame;
		h = f + n1;
		press_key(KEY_REC);
		repeat (n1) wait_phase(40);
		if (pause_frames > 0) begin
			press_key(KEY_REC);
			check_value({name, " pause mode"}, aud_pkg::ST_RECD_PAUSE, mode);
			repeat (pause_frames) wait_phase(40);
			h = now_frame;
			press_key(KEY_REC);
			repeat (n2) wait_phase(40);
		end
		press_key(KEY_STOP);
		wait_stop(name, stop_frame);
		for (i = 0; i < n1; i++) begin
			check_value($sformatf("%s word %0d", name, i), adc_log[f + 1 + i], mem[i]);
		end
		for (i = 0; i < n2; i++) begin
			check_value($sformatf("%s word %0d", name, n1 + i), adc_log[h + 1 + i], mem[n1 + i]);
		end
		check_value({name, " word after end"}, next_old, mem[total]);
		stored_len = total;
		end_test(name);
	endtask

	task automatic run_play(
		input string               name,
		input aud_pkg::play_mode_e pm,
		input int                  spd,
		input int                  pause_after
	);
		int                       f;
		int                       g;
		int                       h;
		int                       fr;
		int                       idx;
		int                       cnt;
		int                       stop_frame;
		logic [`AUD_SAMPLE_W-1:0] exp;
		mode_sel = pm;
		speed = 3'(spd);
		test_err_start = errors;
		g = -1;
		h = -1;
		wait_phase(40);
		f = now_frame;
		press_key(KEY_PLAY);
		if (pause_after > 0) begin
			repeat (pause_after) wait_phase(40);
			g = now_frame;
			press_key(KEY_PLAY);
			check_value({name, " pause mode"}, aud_pkg::ST_PLAY_PAUSE, mode);
			repeat (3) wait_phase(40);
			h = now_frame;
			press_key(KEY_PLAY);
		end
		wait_stop(name, stop_frame);
		// last word finishes shifting in the stop frame
		wait_phase(40);
		check_value({name, " leading frame"}, 0, dac_log[f + 1]);
		cnt = out_count(pm, spd);
		idx = 0;
		fr = f + 2;
		while (idx < cnt) begin
			if (fr > g && fr <= h) begin
				exp = '0;
			end else begin
				exp = expected_sample(pm, spd, idx);
				idx++;
			end
			check_value($sformatf("%s frame %0d", name, fr - f - 1), exp, dac_log[fr]);
			fr++;
		end
		check_value({name, " stop frame"}, fr - 1, stop_frame);
		end_test(name);
	endtask

	task automatic run_full(input string name);
		int f;
		int i;
		int stop_frame;
		test_err_start = errors;
		wait_phase(40);
		f = now_frame;
		press_key(KEY_REC);
		wait_stop(name, stop_frame);
		check_value({name, " stop frame"}, f + MEM_WORDS, stop_frame);
		// no write may follow the full pulse
		repeat (2) wait_phase(40);
		for (i = 0; i < MEM_WORDS; i++) begin
			check_value($sformatf("%s word %0d", name, i), adc_log[f + 1 + i], mem[i]);
		end
		stored_len = MEM_WORDS;
		end_test(name);
	endtask

	initial begin
		int i;
		aud_bclk = 1'b0;
		rst_n = 1'b1;
		key_rec = 1'b0;
		key_play = 1'b0;
		key_stop = 1'b0;
		mode_sel = aud_pkg::PM_NORMAL;
		speed = 3'd0;
		lrck = 1'b1;
		adcdat = 1'b0;
		phase = FRAME_BCLKS / 2;
		frame = -1;
		stored_len = 0;
		errors = 0;
		checks = 0;
		tests = 0;
		for (i = 0; i < MEM_WORDS; i++) begin
			mem[i] = 16'hA5C3 ^ 16'(i * 1031);
		end
		repeat (2) @(posedge aud_bclk);
		#1;
		rst_n = 1'b0;

		run_record("recording", 20, 0, 0);
		run_record("record pause", 5, 3, 5);
		run_play("normal playback", aud_pkg::PM_NORMAL, 0, 0);
		run_play("fast playback", aud_pkg::PM_FAST, 2, 0);
		run_play("slow constant playback", aud_pkg::PM_SLOW_CONST, 1, 5);
		run_play("slow linear playback", aud_pkg::PM_SLOW_LIN, 3, 0);
		run_full("memory full");

		errors = errors + dut_i.chk_i.fail_cnt;
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge aud_bclk);
			cycle_cnt++;
		end
		$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Testbench failed");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+common
common/aud_pkg.sv
aud_i2s/aud_recorder.sv
aud_i2s/aud_player.sv
aud_dsp/aud_dsp.sv
src/aud_ctrl.sv
src/aud_top.sv
verification/aud_top_chk.sv
verification/tb_aud_top.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_aud_top \
	-f flist.f \
	-o tb_aud_top

./obj_dir/tb_aud_top +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "^Testbench passed$" sim.log; then
	echo "simulation result: pass"
	exit 0
else
	echo "simulation result: fail"
	exit 1
fi
